/* source/snapshot_settings.svh */
/*
  Save-state probe settings
  Bridge regions, the unused core memory ranges that get masked,
  the marker word and the handshake and video timing constants.
*/
`ifndef SNAPSHOT_SETTINGS_SVH
`define SNAPSHOT_SETTINGS_SVH

// bridge decode
`define SS_REGION_NIBBLE    4'h4
`define FAILURE_COUNT_ADDR  32'h0000_0000

// replaces words from unused memory
`define SS_MARKER_WORD      64'h0000_0000_FEEB_DAED

// core address bounds of the unused ranges
`define SS_MASK_LO_END      26'd8192
`define SS_CHR_BASE         26'h020_0000
`define SS_CHR_END          26'h030_0000
`define SS_VRAM_BASE        26'h030_0000
`define SS_VRAM_END         26'h030_0800
`define SS_CHRRAM_BASE      26'h038_0000
`define SS_CHRRAM_END       26'h038_0800
`define SS_CARTRAM_BASE     26'h03C_0000
`define SS_CARTRAM_END      26'h040_0000

// timing
`define SS_HOLD_CYCLES      32
`define HS_DELAY_CYCLES     7
`define HALFWORDS_PER_WORD  4

`endif

/* source/snapshot_pkg.sv */
/*
  Save-state probe types
  Packed bundles for the bridge bus, the core save-state port,
  the halfword read path, the handshake status and the video path.
*/
package snapshot_pkg;

  ////////////////////////////////////////////////////////////
  // host bridge side

  typedef struct packed {
    logic [31:0] addr;
    logic        rd;
  } bridge_req_t;

  // halfword read strobe into the serializer
  typedef struct packed {
    logic        rd;
    logic [27:0] addr;
  } ss_read_t;

  typedef struct packed {
    logic ack;
    logic busy;
    logic ok;
  } savestate_status_t;

  ////////////////////////////////////////////////////////////
  // emulation core side

  // a write is req high with rnw low
  typedef struct packed {
    logic        req;
    logic        rnw;
    logic [25:0] addr;
    logic [63:0] wdata;
  } ss_core_req_t;

  typedef struct packed {
    logic        h_blank;
    logic        v_blank;
    logic        hs;
    logic        vs;
    logic [23:0] rgb;
  } core_video_t;

  // scaler facing
  typedef struct packed {
    logic        de;
    logic        hs;
    logic        vs;
    logic [23:0] rgb;
  } video_out_t;

endpackage

/* source/savestate_start_ctrl.sv */
/*
  Save-state start handshake
  Acks a start request edge, holds busy for a fixed window,
  then reports ok. Also pauses the core while either side is busy.
*/
`include "snapshot_settings.svh"

module savestate_start_ctrl import snapshot_pkg::*; (
  input  logic              clk_74a,
  input  logic              reset,
  input  logic              savestate_start,
  input  logic              ss_busy,
  output savestate_status_t status,
  output logic              core_pause
);

  localparam int HOLD  = `SS_HOLD_CYCLES;
  localparam int CNT_W = $clog2(HOLD + 1);

  logic             start_prev;
  logic             start_edge;
  logic [CNT_W-1:0] hold_cnt;

  assign start_edge = savestate_start & ~start_prev;

  always_ff @(posedge clk_74a) begin
    if (reset) begin
      start_prev  <= 1'b0;
      hold_cnt    <= '0;
      status      <= '0;
      core_pause  <= 1'b0;
    end else begin
      start_prev  <= savestate_start;
      status.ack  <= start_edge;
      core_pause  <= status.busy | ss_busy;

      // countdown, busy drops and ok rises on the last count
      if (status.busy) begin
        if (hold_cnt == '0) begin
          status.busy <= 1'b0;
          status.ok   <= 1'b1;
        end else begin
          hold_cnt <= hold_cnt - 1'b1;
        end
      end

      // new request restarts the window and clears the old result
      if (start_edge) begin
        status.busy <= 1'b1;
        status.ok   <= 1'b0;
        hold_cnt    <= CNT_W'(HOLD);
      end
    end
  end

  // busy window never shorter than the hold count
  busy_full_window: assert property (
    @(posedge clk_74a) disable iff (reset) $fell(status.busy) |-> $past(status.busy, HOLD + 1)
  ) else $error("save-state busy window ended before the full hold count");

endmodule

/* source/ss_word_serializer.sv */
/*
  Save-state word serializer
  Buffers one 64-bit word from the core, swaps in a marker for
  unused memory, and shifts it out to the bridge as four halfwords.
  Counts reads whose bridge address disagrees with the core address.
*/
`include "snapshot_settings.svh"

module ss_word_serializer import snapshot_pkg::*; (
  input  logic         clk_74a,
  input  logic         reset,
  input  ss_core_req_t core_req,
  input  ss_read_t     rd,
  output logic         ss_ack,
  output logic [15:0]  halfword,
  output logic [31:0]  failure_count
);

  localparam int HW_CNT_W = $clog2(`HALFWORDS_PER_WORD);
  localparam int HW_LAST  = `HALFWORDS_PER_WORD - 1;

  logic                core_wr;
  logic                masked;
  logic                addr_mismatch;
  logic [63:0]         word_buf;
  logic [HW_CNT_W-1:0] hw_count;

  assign core_wr = core_req.req & ~core_req.rnw;

  ////////////////////////////////////////////////////////////
  // unused memory ranges

  // gaps after oam/mapper, chr, chr vram, chr ram and cart ram
  always_comb begin
    masked = 1'b0;
    if (core_req.addr > `SS_MASK_LO_END && core_req.addr < `SS_CHR_BASE) begin
      masked = 1'b1;
    end
    if (core_req.addr > `SS_CHR_END && core_req.addr < `SS_VRAM_BASE) begin
      masked = 1'b1;
    end
    if (core_req.addr > `SS_VRAM_END && core_req.addr < `SS_CHRRAM_BASE) begin
      masked = 1'b1;
    end
    if (core_req.addr > `SS_CHRRAM_END && core_req.addr < `SS_CARTRAM_BASE) begin
      masked = 1'b1;
    end
    if (core_req.addr > `SS_CARTRAM_END) begin
      masked = 1'b1;
    end
  end

  // only the low 22 bits are comparable between the two sides
  assign addr_mismatch = core_req.addr[21:0] != rd.addr[21:0];

  ////////////////////////////////////////////////////////////
  // word buffer

  always_ff @(posedge clk_74a) begin
    if (core_wr) begin
      word_buf <= masked ? `SS_MARKER_WORD : core_req.wdata;
    end else if (rd.rd) begin
      // next halfword moves to the bottom
      word_buf <= {16'h0000, word_buf[63:16]};
    end
  end

  assign halfword = word_buf[15:0];

  ////////////////////////////////////////////////////////////
  // halfword count, core ack and mismatch count

  always_ff @(posedge clk_74a) begin
    if (reset) begin
      hw_count      <= '0;
      ss_ack        <= 1'b0;
      failure_count <= '0;
    end else begin
      ss_ack <= 1'b0;

      if (rd.rd) begin
        hw_count <= hw_count + 1'b1;
        // last halfword out, core may send the next word
        if (hw_count == HW_CNT_W'(HW_LAST)) begin
          ss_ack <= 1'b1;
        end
        if (!masked && addr_mismatch) begin
          failure_count <= failure_count + 1'b1;
        end
      end
    end
  end

  // core waits for ack, so bridge reads never overlap a load
  no_write_during_read: assert property (
    @(posedge clk_74a) disable iff (reset) !(core_wr && rd.rd)
  ) else $error("core write collided with a halfword read");

endmodule

/* source/bridge_read_port.sv */
/*
  Bridge read port
  Decodes bridge reads into the failure count or the save-state
  halfword stream and registers the read data for the host.
*/
`include "snapshot_settings.svh"

module bridge_read_port import snapshot_pkg::*; (
  input  logic        clk_74a,
  input  logic        reset,
  input  bridge_req_t bridge,
  output ss_read_t    rd,
  input  logic [15:0] halfword,
  input  logic [31:0] failure_count,
  output logic [31:0] bridge_rd_data
);

  logic in_region;
  logic is_fail_addr;

  ////////////////////////////////////////////////////////////
  // address decode

  assign in_region    = bridge.addr[31:28] == `SS_REGION_NIBBLE;
  assign is_fail_addr = bridge.addr == `FAILURE_COUNT_ADDR;

  // same cycle strobe into the serializer
  assign rd.rd   = bridge.rd & in_region;
  assign rd.addr = bridge.addr[27:0];

  ////////////////////////////////////////////////////////////
  // read data register

  // held until the next read
  always_ff @(posedge clk_74a) begin
    if (reset) begin
      bridge_rd_data <= '0;
    end else if (bridge.rd) begin
      if (is_fail_addr) begin
        bridge_rd_data <= failure_count;
      end else if (in_region) begin
        bridge_rd_data <= {16'h0000, halfword};
      end else begin
        bridge_rd_data <= '0;
      end
    end
  end

endmodule

/* source/video_sync_conditioner.sv */
/*
  Video sync conditioner
  Turns core blanking and syncs into data enable, gated colour,
  a delayed single-cycle hsync and a single-cycle vsync.
*/
`include "snapshot_settings.svh"

module video_sync_conditioner import snapshot_pkg::*; (
  input  logic        clk_74a,
  input  logic        reset,
  input  core_video_t core_video,
  output video_out_t  video_out
);

  localparam int HS_DLY = `HS_DELAY_CYCLES;
  localparam int DLY_W  = $clog2(HS_DLY + 1);

  logic             active;
  logic             hs_prev;
  logic             vs_prev;
  logic [DLY_W-1:0] hs_delay;

  assign active = ~(core_video.h_blank | core_video.v_blank);

  always_ff @(posedge clk_74a) begin
    if (reset) begin
      video_out <= '0;
      hs_prev   <= 1'b0;
      vs_prev   <= 1'b0;
      hs_delay  <= '0;
    end else begin
      hs_prev <= core_video.hs;
      vs_prev <= core_video.vs;

      // colour only while visible
      video_out.de  <= active;
      video_out.rgb <= active ? core_video.rgb : 24'h0;

      // vsync pulse right on the rise
      video_out.vs <= core_video.vs & ~vs_prev;

      // hsync pushed later to keep it clear of vsync
      video_out.hs <= hs_delay == DLY_W'(1);
      if (hs_delay != '0) begin
        hs_delay <= hs_delay - 1'b1;
      end
      if (core_video.hs && !hs_prev) begin
        hs_delay <= DLY_W'(HS_DLY);
      end
    end
  end

  // scaler cannot take both syncs in one cycle
  syncs_apart: assert property (
    @(posedge clk_74a) disable iff (reset) !(video_out.hs && video_out.vs)
  ) else $error("hsync and vsync pulses overlap");

endmodule

/* source/snapshot_core_top.sv */
/*
  Save-state probe top
  Wires the start handshake, word serializer, bridge read port
  and video conditioning to the bridge, core and video ports.
*/
module snapshot_core_top import snapshot_pkg::*; (
  input  logic              clk_74a,
  input  logic              reset,

  // host bridge
  input  bridge_req_t       bridge,
  output logic [31:0]       bridge_rd_data,

  // save-state handshake
  input  logic              savestate_start,
  output savestate_status_t status,
  input  logic              ss_busy,
  output logic              core_pause,

  // core save-state port
  input  ss_core_req_t      core_req,
  output logic              ss_ack,

  // video
  input  core_video_t       core_video,
  output video_out_t        video_out
);

  ss_read_t    rd;
  logic [15:0] halfword;
  logic [31:0] failure_count;

  savestate_start_ctrl i_start_ctrl (
    .clk_74a         (clk_74a),
    .reset           (reset),
    .savestate_start (savestate_start),
    .ss_busy         (ss_busy),
    .status          (status),
    .core_pause      (core_pause)
  );

  ss_word_serializer i_serializer (
    .clk_74a       (clk_74a),
    .reset         (reset),
    .core_req      (core_req),
    .rd            (rd),
    .ss_ack        (ss_ack),
    .halfword      (halfword),
    .failure_count (failure_count)
  );

  bridge_read_port i_read_port (
    .clk_74a        (clk_74a),
    .reset          (reset),
    .bridge         (bridge),
    .rd             (rd),
    .halfword       (halfword),
    .failure_count  (failure_count),
    .bridge_rd_data (bridge_rd_data)
  );

  video_sync_conditioner i_video (
    .clk_74a    (clk_74a),
    .reset      (reset),
    .core_video (core_video),
    .video_out  (video_out)
  );

endmodule

/* verification/tb_snapshot_core_top.sv */
/*
  Save-state probe testbench
  Directed tests for the start handshake, halfword stream, masked
  ranges, mismatch counting and video conditioning.
*/
`include "snapshot_settings.svh"

module tb_snapshot_core_top import snapshot_pkg::*; ();

  localparam int CLK_PERIOD   = 40;
  localparam int DRIVE_DLY    = 2;
  localparam int HOLD         = `SS_HOLD_CYCLES;
  localparam int HS_DELAY     = `HS_DELAY_CYCLES;
  localparam int HW_LAST      = `HALFWORDS_PER_WORD - 1;
  localparam int VIDEO_CYCLES = 20;
  // reset, handshake, eight streamed words, loose reads, video, then margin
  localparam int TEST_CYCLES  = 4 + (HOLD + 10) + 8 * 7 + 10 + VIDEO_CYCLES + 2;
  localparam int MARGIN       = 100;

  logic              clk_74a;
  logic              reset;
  bridge_req_t       bridge;
  logic [31:0]       bridge_rd_data;
  logic              savestate_start;
  savestate_status_t status;
  logic              ss_busy;
  logic              core_pause;
  ss_core_req_t      core_req;
  logic              ss_ack;
  core_video_t       core_video;
  video_out_t        video_out;

  string test_name;
  int    check_count;
  int    error_count;
  int    expected_failures;

  snapshot_core_top i_dut (
    .clk_74a         (clk_74a),
    .reset           (reset),
    .bridge          (bridge),
    .bridge_rd_data  (bridge_rd_data),
    .savestate_start (savestate_start),
    .status          (status),
    .ss_busy         (ss_busy),
    .core_pause      (core_pause),
    .core_req        (core_req),
    .ss_ack          (ss_ack),
    .core_video      (core_video),
    .video_out       (video_out)
  );

  always #(CLK_PERIOD / 2) clk_74a = ~clk_74a;

  ////////////////////////////////////////////////////////////
  // compare tasks

  task automatic check_data(input string what, input logic [31:0] exp, input logic [31:0] act);
    check_count++;
    if (act !== exp) begin
      error_count++;
      $display("FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic check_flag(input string what, input logic exp, input logic act);
    check_count++;
    if (act !== exp) begin
      error_count++;
      $display("FAILED %s %s: expected %b, actual %b", test_name, what, exp, act);
    end
  endtask

  task automatic check_status(input string what, input savestate_status_t exp,
                              input savestate_status_t act);
    check_count++;
    if (act !== exp) begin
      error_count++;
      $display("FAILED %s %s: expected %b, actual %b", test_name, what, exp, act);
    end
  endtask

  task automatic check_video(input string what, input video_out_t exp, input video_out_t act);
    check_count++;
    if (act !== exp) begin
      error_count++;
      $display("FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // bus helpers

  // outputs are settled and inputs change here
  task automatic next_cycle();
    @(posedge clk_74a);
    #(DRIVE_DLY);
  endtask

  task automatic read_bridge(input logic [31:0] addr, output logic [31:0] data);
    bridge.addr = addr;
    bridge.rd   = 1'b1;
    next_cycle();
    data        = bridge_rd_data;
    bridge.rd   = 1'b0;
  endtask

  // core keeps the address after the write, only req drops
  task automatic write_word(input logic [25:0] addr, input logic [63:0] data);
    core_req.req   = 1'b1;
    core_req.rnw   = 1'b0;
    core_req.addr  = addr;
    core_req.wdata = data;
    next_cycle();
    core_req.req   = 1'b0;
    core_req.rnw   = 1'b1;
  endtask

  // bad_reads flips bit 0 of the read address, hi_bits fills bits 27:26
  task automatic stream_word(input logic [25:0] addr, input logic [63:0] data,
                             input logic masked, input logic [3:0] bad_reads,
                             input logic [1:0] hi_bits);
    logic [63:0] exp_word;
    logic [31:0] raddr;
    logic [31:0] rdata;
    exp_word = masked ? `SS_MARKER_WORD : data;
    write_word(addr, data);
    for (int i = 0; i <= HW_LAST; i++) begin
      raddr = {`SS_REGION_NIBBLE, hi_bits, addr};
      if (bad_reads[i]) begin
        raddr[0] = ~raddr[0];
      end
      read_bridge(raddr, rdata);
      check_data($sformatf("halfword %0d", i), {16'h0000, exp_word[16*i +: 16]}, rdata);
      check_flag($sformatf("ss_ack after read %0d", i), i == HW_LAST, ss_ack);
      if (bad_reads[i] && !masked) begin
        expected_failures++;
      end
    end
    next_cycle();
    check_flag("ss_ack after word", 1'b0, ss_ack);
  endtask

  ////////////////////////////////////////////////////////////
  // tests

  task automatic check_reset_values();
    test_name = "reset";
    check_status("status", '0, status);
    check_flag("core_pause", 1'b0, core_pause);
    check_flag("ss_ack", 1'b0, ss_ack);
    check_video("video_out", '0, video_out);
    check_data("read data", 32'h0, bridge_rd_data);
  endtask

  task automatic run_start_handshake();
    int   busy_cycles;
    logic prev_busy;
    test_name       = "start_handshake";
    prev_busy       = status.busy;
    savestate_start = 1'b1;
    next_cycle();
    // ack and busy together, ok cleared
    check_status("ack", 3'b110, status);
    check_flag("core_pause", prev_busy, core_pause);
    busy_cycles = 1;
    prev_busy   = status.busy;
    while (status.busy) begin
      if (busy_cycles > HOLD + 10) begin
        error_count++;
        $display("start handshake: busy did not drop within %0d cycles", HOLD + 10);
        break;
      end
      next_cycle();
      check_flag("ack", 1'b0, status.ack);
      check_flag("core_pause", prev_busy, core_pause);
      prev_busy = status.busy;
      if (status.busy) begin
        busy_cycles++;
      end
    end
    check_data("busy cycles", HOLD + 1, busy_cycles);
    check_status("ok", 3'b001, status);
    savestate_start = 1'b0;
    next_cycle();
    check_flag("core_pause after busy", 1'b0, core_pause);
    check_status("ok held", 3'b001, status);
    // core side busy also pauses
    ss_busy = 1'b1;
    next_cycle();
    check_flag("core_pause from core", 1'b1, core_pause);
    ss_busy = 1'b0;
    next_cycle();
    check_flag("core_pause released", 1'b0, core_pause);
  endtask

  task automatic run_halfword_stream();
    logic [31:0] rdata;
    test_name = "halfword_stream";
    stream_word(26'($urandom % 8192), {$urandom, $urandom}, 1'b0, 4'b0000, 2'b00);
    read_bridge(`FAILURE_COUNT_ADDR, rdata);
    check_data("failure count", 32'h0, rdata);
  endtask

  task automatic run_masked_ranges();
    logic [31:0] rdata;
    test_name = "masked_ranges";
    // one address per gap, the gap between chr and vram is empty
    stream_word(26'h010_0000, {$urandom, $urandom}, 1'b1, 4'b1111, 2'b00);
    stream_word(26'h034_0000, {$urandom, $urandom}, 1'b1, 4'b1111, 2'b00);
    stream_word(26'h03A_0000, {$urandom, $urandom}, 1'b1, 4'b1111, 2'b00);
    stream_word(26'h200_0000, {$urandom, $urandom}, 1'b1, 4'b1111, 2'b00);
    read_bridge(`FAILURE_COUNT_ADDR, rdata);
    check_data("failure count", expected_failures, rdata);
  endtask

  task automatic run_mismatch_count();
    logic [31:0] rdata;
    test_name = "mismatch_count";
    stream_word(26'h021_0040, {$urandom, $urandom}, 1'b0, 4'b0101, 2'b00);
    stream_word(26'h000_0100, {$urandom, $urandom}, 1'b0, 4'b1110, 2'b00);
    // upper read address bits are outside the compare
    stream_word(26'h030_0400, {$urandom, $urandom}, 1'b0, 4'b0000, 2'b11);
    read_bridge(`FAILURE_COUNT_ADDR, rdata);
    check_data("failure count", expected_failures, rdata);
    read_bridge(32'h1000_0000, rdata);
    check_data("unmapped 10000000", 32'h0, rdata);
    read_bridge(32'h0000_0004, rdata);
    check_data("unmapped 00000004", 32'h0, rdata);
    read_bridge(32'h5000_0000, rdata);
    check_data("unmapped 50000000", 32'h0, rdata);
  endtask

  task automatic run_video_test();
    core_video_t cv;
    video_out_t  exp;
    logic        prev_vs;
    logic        prev_hs;
    int          hs_rise;
    test_name = "video";
    prev_vs   = 1'b0;
    prev_hs   = 1'b0;
    hs_rise   = -100;
    for (int k = 0; k < VIDEO_CYCLES; k++) begin
      cv.h_blank = (k < 4) || (k >= 16 && k < 18);
      cv.v_blank = (k >= 10 && k < 12);
      cv.vs      = (k >= 3 && k < 6);
      cv.hs      = (k >= 6 && k < 9);
      cv.rgb     = 24'($urandom);
      core_video = cv;
      if (cv.hs && !prev_hs) begin
        hs_rise = k;
      end
      exp.de  = !(cv.h_blank || cv.v_blank);
      exp.rgb = exp.de ? cv.rgb : 24'h0;
      exp.vs  = cv.vs && !prev_vs;
      // rise registered on this edge, pulse HS_DELAY edges later
      exp.hs  = (k == hs_rise + HS_DELAY);
      next_cycle();
      check_video($sformatf("cycle %0d", k), exp, video_out);
      prev_vs = cv.vs;
      prev_hs = cv.hs;
    end
    core_video = '0;
    next_cycle();
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence and watchdog

  initial begin
    void'($urandom(30611));
    check_count       = 0;
    error_count       = 0;
    expected_failures = 0;
    clk_74a           = 1'b0;
    reset             = 1'b1;
    bridge            = '0;
    savestate_start   = 1'b0;
    ss_busy           = 1'b0;
    core_req          = '0;
    core_video        = '0;
    repeat (2) next_cycle();
    reset = 1'b0;
    check_reset_values();
    run_start_handshake();
    run_halfword_stream();
    run_masked_ranges();
    run_mismatch_count();
    run_video_test();
    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  initial begin
    #((TEST_CYCLES + MARGIN) * CLK_PERIOD);
    $display("watchdog expired before the tests finished");
    $display("sim failed");
    $finish;
  end

endmodule

/* build.f */
+incdir+source
source/snapshot_pkg.sv
source/savestate_start_ctrl.sv
source/ss_word_serializer.sv
source/bridge_read_port.sv
source/video_sync_conditioner.sv
source/snapshot_core_top.sv
verification/tb_snapshot_core_top.sv
